//--- compile.f
src/div_pkg.sv
src/div_stage_control.sv
src/div_nonrestoring.sv
src/div_result_fifo.sv
src/div_top.sv
dv/tb_clock_gen.sv
dv/tb_div_top.sv

//--- Makefile
TOP = tb_div_top
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_div_top.sv
/*
 * Testbench for the pipelined signed divider:
 *   xorshift stimulus, directed and random operands
 *   queue model using truncating signed division
 *   typed compare tasks, stall stability monitor
 *   watchdog and per-test reporting
 */
`timescale 1ns/1ps

module tb_div_top;

    localparam int DRIVE_DELAY  = 1;
    localparam int CLK_PERIOD   = 100;
    localparam int DIRECTED_OPS = 16;
    localparam int STREAM_OPS   = 500;
    localparam int BP_OPS       = 300;
    localparam int STALL_LIMIT  = div_pkg::PIPE_STAGES + div_pkg::FIFO_DEPTH;
    localparam int WATCHDOG_CYCLES =
        (DIRECTED_OPS + STREAM_OPS + BP_OPS + STALL_LIMIT) * div_pkg::PIPE_STAGES + 1000;
    localparam int READY_HIGH   = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW    = 2;
    localparam div_pkg::dividend_t MIN_DIVIDEND = 16'sh8000;
    localparam div_pkg::divisor_t  MINUS_ONE    = -16'sd1;

    logic                clk;
    logic                reset;
    logic                in_valid;
    logic                in_ready;
    div_pkg::tag_t       in_tag;
    div_pkg::dividend_t  in_dividend;
    div_pkg::divisor_t   in_divisor;
    logic                out_valid;
    logic                out_ready;
    div_pkg::tag_t       out_tag;
    div_pkg::quotient_t  out_quotient;
    div_pkg::remainder_t out_remainder;

    div_pkg::tag_t       exp_tag_q[$];
    div_pkg::quotient_t  exp_quot_q[$];
    div_pkg::remainder_t exp_rem_q[$];

    logic [31:0]   stim_state = 32'hda35;
    logic [31:0]   ready_state = 32'hda35 ^ 32'h9e3779b9;
    logic [7:0]    idle_level = 8'd0;
    int            ready_mode = READY_HIGH;
    div_pkg::tag_t next_tag = '0;
    int            error_count = 0;
    int            test_errors = 0;
    int            tests_run = 0;
    int            tests_failed = 0;
    int            recv_count = 0;
    int            cycle = 0;
    int            first_in_cycle = -1;
    int            first_out_cycle = -1;

    // stalled head entry as seen one cycle earlier
    logic                held_valid = 1'b0;
    div_pkg::tag_t       held_tag;
    div_pkg::quotient_t  held_quot;
    div_pkg::remainder_t held_rem;

    // sign combinations, exact divisions, divisor larger than dividend, extremes
    div_pkg::dividend_t dir_dividend [DIRECTED_OPS] = '{
        16'sd100, -16'sd100, 16'sd100, -16'sd100, 16'sd84, -16'sd84, 16'sd84, -16'sd84,
        16'sd5, -16'sd5, 16'sd5, -16'sd5, 16'sd0, 16'sh8000, 16'sd32767, 16'sh8000};
    div_pkg::divisor_t dir_divisor [DIRECTED_OPS] = '{
        16'sd7, 16'sd7, -16'sd7, -16'sd7, 16'sd7, 16'sd7, -16'sd7, -16'sd7,
        16'sd300, 16'sd300, -16'sd300, -16'sd300, 16'sd9, 16'sd32767, -16'sd1, 16'sd1};

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    div_top dut (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_tag        (in_tag),
        .in_dividend   (in_dividend),
        .in_divisor    (in_divisor),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_tag       (out_tag),
        .out_quotient  (out_quotient),
        .out_remainder (out_remainder)
    );

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_tag(input string name, input div_pkg::tag_t expected,
                             input div_pkg::tag_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_quotient(input string name, input div_pkg::quotient_t expected,
                                  input div_pkg::quotient_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_remainder(input string name, input div_pkg::remainder_t expected,
                                   input div_pkg::remainder_t actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // zero divisor and the overflow pair are drawn again
    task automatic random_operands(output div_pkg::dividend_t d, output div_pkg::divisor_t v);
        d = '0;
        v = '0;
        while (v == '0 || (d == MIN_DIVIDEND && v == MINUS_ONE)) begin
            stim_state = xorshift32(stim_state);
            d = div_pkg::dividend_t'(stim_state[15:0]);
            v = div_pkg::divisor_t'(stim_state[31:16]);
            stim_state = xorshift32(stim_state);
            if (stim_state[0]) begin
                v = v >>> stim_state[4:1];
            end
            if (stim_state[5]) begin
                d = d >>> stim_state[9:6];
            end
        end
    endtask

    // called just after a rising edge, returns just after the accepting edge
    task automatic send_op(input div_pkg::dividend_t d, input div_pkg::divisor_t v);
        logic done;
        stim_state = xorshift32(stim_state);
        while (stim_state[7:0] < idle_level) begin
            @(posedge clk);
            #DRIVE_DELAY;
            stim_state = xorshift32(stim_state);
        end
        in_valid    = 1'b1;
        in_tag      = next_tag;
        in_dividend = d;
        in_divisor  = v;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
        next_tag = next_tag + div_pkg::tag_t'(1);
    endtask

    task automatic wait_drain();
        while (exp_tag_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (out_valid) begin
            report_failure("extra result after all operations completed");
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (error_count != test_errors) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", tests_run, name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // ------------------------------------------------------------------------
    // output ready driver and monitor
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        #DRIVE_DELAY;
        ready_state = xorshift32(ready_state);
        case (ready_mode)
            READY_RANDOM: out_ready = ready_state[0];
            READY_LOW:    out_ready = 1'b0;
            default:      out_ready = 1'b1;
        endcase
    end

    // mid-cycle view of the transfers that happen on the next edge
    always @(negedge clk) begin
        cycle++;
        if (!reset) begin
            if (in_valid && in_ready) begin
                exp_tag_q.push_back(in_tag);
                exp_quot_q.push_back(in_dividend / in_divisor);
                exp_rem_q.push_back(in_dividend % in_divisor);
                if (first_in_cycle < 0) begin
                    first_in_cycle = cycle;
                end
            end
            if (out_valid && first_out_cycle < 0) begin
                first_out_cycle = cycle;
            end
            if (held_valid) begin
                if (!out_valid) begin
                    report_failure("out_valid dropped while out_ready was low");
                end else begin
                    check_tag("out_tag (stalled)", held_tag, out_tag);
                    check_quotient("out_quotient (stalled)", held_quot, out_quotient);
                    check_remainder("out_remainder (stalled)", held_rem, out_remainder);
                end
            end
            if (out_valid && out_ready) begin
                recv_count++;
                if (exp_tag_q.size() == 0) begin
                    report_failure("result arrived with no operation pending");
                end else begin
                    check_tag("out_tag", exp_tag_q.pop_front(), out_tag);
                    check_quotient("out_quotient", exp_quot_q.pop_front(), out_quotient);
                    check_remainder("out_remainder", exp_rem_q.pop_front(), out_remainder);
                end
            end
            held_valid = out_valid && !out_ready;
            held_tag   = out_tag;
            held_quot  = out_quotient;
            held_rem   = out_remainder;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("error: watchdog expired after %0d cycles, run did not complete",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------

    initial begin : main_seq
        div_pkg::dividend_t d;
        div_pkg::divisor_t  v;
        logic               stalled;
        logic               done;
        int                 accepted;
        int                 start_recv;

        in_valid    = 1'b0;
        in_tag      = '0;
        in_dividend = '0;
        in_divisor  = '0;
        out_ready   = 1'b1;
        wait (reset === 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;

        @(negedge clk);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_ready", 1'b1, in_ready);
        @(posedge clk);
        #DRIVE_DELAY;
        end_test("reset state");

        for (int i = 0; i < DIRECTED_OPS; i++) begin
            send_op(dir_dividend[i], dir_divisor[i]);
        end
        wait_drain();
        end_test("directed signs");

        first_in_cycle  = -1;
        first_out_cycle = -1;
        start_recv      = recv_count;
        for (int i = 0; i < STREAM_OPS; i++) begin
            random_operands(d, v);
            send_op(d, v);
        end
        wait_drain();
        if (first_out_cycle - first_in_cycle != div_pkg::PIPE_STAGES + 1) begin
            report_failure($sformatf("first result latency %0d cycles, expected %0d",
                first_out_cycle - first_in_cycle, div_pkg::PIPE_STAGES + 1));
        end
        if (recv_count - start_recv != STREAM_OPS) begin
            report_failure("random stream result count does not match operations sent");
        end
        end_test("random stream");

        ready_mode = READY_RANDOM;
        idle_level = 8'd128;
        start_recv = recv_count;
        for (int i = 0; i < BP_OPS; i++) begin
            random_operands(d, v);
            send_op(d, v);
        end
        wait_drain();
        if (recv_count - start_recv != BP_OPS) begin
            report_failure("back-pressure result count does not match operations sent");
        end
        end_test("random back-pressure");

        // pipeline and FIFO fill up behind a blocked consumer
        ready_mode = READY_LOW;
        idle_level = 8'd0;
        repeat (2) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        stalled  = 1'b0;
        accepted = 0;
        while (!stalled && accepted <= STALL_LIMIT) begin
            random_operands(d, v);
            in_valid    = 1'b1;
            in_tag      = next_tag;
            in_dividend = d;
            in_divisor  = v;
            @(negedge clk);
            if (in_ready) begin
                accepted++;
                next_tag = next_tag + div_pkg::tag_t'(1);
                @(posedge clk);
                #DRIVE_DELAY;
            end else begin
                stalled = 1'b1;
            end
        end
        if (!stalled) begin
            report_failure("in_ready never dropped with out_ready held low");
        end
        if (accepted > STALL_LIMIT) begin
            report_failure($sformatf("%0d operations accepted during stall, limit %0d",
                accepted, STALL_LIMIT));
        end
        ready_mode = READY_HIGH;
        @(posedge clk);
        #DRIVE_DELAY;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = in_ready;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
        next_tag = next_tag + div_pkg::tag_t'(1);
        wait_drain();
        end_test("full stall");

        $display("tests run %0d, tests failed %0d, errors %0d, results received %0d",
                 tests_run, tests_failed, error_count, recv_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
/*
 * Clock and reset source for the divider testbench:
 *   100 ns period clock
 *   synchronous reset held for four cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, like the other drivers
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

//--- src/div_top.sv
/*
 * Top level of the pipelined signed divider:
 *   stage control for valid tracking and stalls
 *   non-restoring divider datapath
 *   result FIFO on the output stream
 *   divide-by-zero check on accepted operands
 */
`timescale 1ns/1ps

module div_top (
    input  logic                clk,
    input  logic                reset,

    // operand stream
    input  logic                in_valid,
    output logic                in_ready,
    input  div_pkg::tag_t       in_tag,
    input  div_pkg::dividend_t  in_dividend,
    input  div_pkg::divisor_t   in_divisor,

    // result stream
    output logic                out_valid,
    input  logic                out_ready,
    output div_pkg::tag_t       out_tag,
    output div_pkg::quotient_t  out_quotient,
    output div_pkg::remainder_t out_remainder
);

    logic [div_pkg::PIPE_STAGES-1:0] stage_en;
    logic                            push;
    logic                            full;

    div_pkg::tag_t       res_tag;
    div_pkg::quotient_t  res_quotient;
    div_pkg::remainder_t res_remainder;

    div_stage_control u_stage_control (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .full     (full),
        .stage_en (stage_en),
        .in_ready (in_ready),
        .push     (push)
    );

    div_nonrestoring u_divider (
        .clk           (clk),
        .stage_en      (stage_en),
        .in_tag        (in_tag),
        .in_dividend   (in_dividend),
        .in_divisor    (in_divisor),
        .res_tag       (res_tag),
        .res_quotient  (res_quotient),
        .res_remainder (res_remainder)
    );

    div_result_fifo u_result_fifo (
        .clk            (clk),
        .reset          (reset),
        .push           (push),
        .push_tag       (res_tag),
        .push_quotient  (res_quotient),
        .push_remainder (res_remainder),
        .full           (full),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_tag        (out_tag),
        .out_quotient   (out_quotient),
        .out_remainder  (out_remainder)
    );

    // divide by zero has no defined result
    a_divisor_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        in_valid && in_ready |-> in_divisor != '0
    ) else $error("divide by zero on the operand stream");

endmodule

//--- src/div_result_fifo.sv
/*
 * Result buffer for the divider:
 *   circular storage for tag, quotient and remainder
 *   read/write pointers and entry count
 *   first-word-fall-through output with valid/ready
 */
`timescale 1ns/1ps

module div_result_fifo (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  div_pkg::tag_t       push_tag,
    input  div_pkg::quotient_t  push_quotient,
    input  div_pkg::remainder_t push_remainder,
    output logic                full,
    output logic                out_valid,
    input  logic                out_ready,
    output div_pkg::tag_t       out_tag,
    output div_pkg::quotient_t  out_quotient,
    output div_pkg::remainder_t out_remainder
);

    div_pkg::tag_t       mem_tag  [div_pkg::FIFO_DEPTH];
    div_pkg::quotient_t  mem_quot [div_pkg::FIFO_DEPTH];
    div_pkg::remainder_t mem_rem  [div_pkg::FIFO_DEPTH];

    logic [div_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr;
    logic [div_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr;
    logic [div_pkg::FIFO_CNT_WIDTH-1:0] count;
    logic                               pop;

    assign full      = count == div_pkg::FIFO_FULL_COUNT;
    assign out_valid = count != '0;
    assign pop       = out_valid && out_ready;

    // head entry shows directly on the output
    assign out_tag       = mem_tag[rd_ptr];
    assign out_quotient  = mem_quot[rd_ptr];
    assign out_remainder = mem_rem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_tag[wr_ptr]  <= push_tag;
            mem_quot[wr_ptr] <= push_quotient;
            mem_rem[wr_ptr]  <= push_remainder;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == div_pkg::FIFO_LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == div_pkg::FIFO_LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= div_pkg::FIFO_FULL_COUNT
    ) else $error("result FIFO count above depth");

    // head entry must not change while the consumer stalls
    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_tag)
            && $stable(out_quotient) && $stable(out_remainder)
    ) else $error("output changed while stalled");

endmodule

//--- src/div_nonrestoring.sv
/*
 * Non-restoring signed divider datapath:
 *   operand register
 *   one register stage per quotient bit
 *   normalization stage for truncating quotient and remainder
 * Valid tracking lives in the stage control.
 */
`timescale 1ns/1ps

module div_nonrestoring (
    input  logic                            clk,
    input  logic [div_pkg::PIPE_STAGES-1:0] stage_en,
    input  div_pkg::tag_t                   in_tag,
    input  div_pkg::dividend_t              in_dividend,
    input  div_pkg::divisor_t               in_divisor,
    output div_pkg::tag_t                   res_tag,
    output div_pkg::quotient_t              res_quotient,
    output div_pkg::remainder_t             res_remainder
);

    // ------------------------------------------------------------------------
    // operand register
    // ------------------------------------------------------------------------

    div_pkg::tag_t      op_tag;
    div_pkg::dividend_t op_dividend;
    div_pkg::divisor_t  op_divisor;

    always_ff @(posedge clk) begin
        if (stage_en[0]) begin
            op_tag      <= in_tag;
            op_dividend <= in_dividend;
            op_divisor  <= in_divisor;
        end
    end

    // ------------------------------------------------------------------------
    // iteration stages
    // ------------------------------------------------------------------------

    // index 0 is fed by the operand register, index i+1 by stage i
    logic [div_pkg::QUOT_WIDTH:0][div_pkg::TAG_WIDTH-1:0]     chain_tag;
    logic [div_pkg::QUOT_WIDTH:0]                             chain_sign;
    logic [div_pkg::QUOT_WIDTH:0][div_pkg::DIVISOR_WIDTH-1:0] chain_div;
    logic [div_pkg::QUOT_WIDTH:0][div_pkg::QUOT_WIDTH-1:0]    chain_quot;
    logic [div_pkg::QUOT_WIDTH:0][div_pkg::REM_WIDTH-1:0]     chain_rem;

    // sign-extended dividend forms the initial remainder/quotient pair
    assign chain_tag[0]  = op_tag;
    assign chain_sign[0] = op_dividend[div_pkg::DIVIDEND_WIDTH-1];
    assign chain_div[0]  = op_divisor;
    assign chain_quot[0] = op_dividend;
    assign chain_rem[0]  = {div_pkg::REM_WIDTH{op_dividend[div_pkg::DIVIDEND_WIDTH-1]}};

    for (genvar i = 0; i < div_pkg::QUOT_WIDTH; i++) begin : g_iter
        div_pkg::remainder_t                cur_rem;
        div_pkg::quotient_t                 cur_quot;
        div_pkg::divisor_t                  cur_div;
        logic signed [div_pkg::REM_WIDTH:0] shift_rem;
        logic signed [div_pkg::REM_WIDTH:0] sub_rem;
        logic signed [div_pkg::REM_WIDTH:0] add_rem;
        logic                               q_bit;

        div_pkg::tag_t       reg_tag;
        logic                reg_sign;
        div_pkg::divisor_t   reg_div;
        div_pkg::quotient_t  reg_quot;
        div_pkg::remainder_t reg_rem;

        assign cur_rem  = chain_rem[i];
        assign cur_quot = chain_quot[i];
        assign cur_div  = chain_div[i];

        // pair shifted left by one, top quotient bit moves into the remainder
        assign shift_rem = {cur_rem, cur_quot[div_pkg::QUOT_WIDTH-1]};
        assign sub_rem   = shift_rem - cur_div;
        assign add_rem   = shift_rem + cur_div;

        // subtract when signs match, add otherwise
        assign q_bit = shift_rem[div_pkg::REM_WIDTH] == cur_div[div_pkg::DIVISOR_WIDTH-1];

        always_ff @(posedge clk) begin
            if (stage_en[i+1]) begin
                reg_tag  <= chain_tag[i];
                reg_sign <= chain_sign[i];
                reg_div  <= cur_div;
                reg_quot <= {cur_quot[div_pkg::QUOT_WIDTH-2:0], q_bit};
                if (q_bit) begin
                    reg_rem <= sub_rem[div_pkg::REM_WIDTH-1:0];
                end else begin
                    reg_rem <= add_rem[div_pkg::REM_WIDTH-1:0];
                end
            end
        end

        assign chain_tag[i+1]  = reg_tag;
        assign chain_sign[i+1] = reg_sign;
        assign chain_div[i+1]  = reg_div;
        assign chain_quot[i+1] = reg_quot;
        assign chain_rem[i+1]  = reg_rem;
    end

    // ------------------------------------------------------------------------
    // normalization stage
    // ------------------------------------------------------------------------

    div_pkg::tag_t       last_tag;
    logic                last_sign;
    div_pkg::divisor_t   last_div;
    div_pkg::quotient_t  last_quot;
    div_pkg::remainder_t last_rem;
    logic                rem_sign;
    logic                step_up;
    logic                step_down;

    assign last_tag  = chain_tag[div_pkg::QUOT_WIDTH];
    assign last_sign = chain_sign[div_pkg::QUOT_WIDTH];
    assign last_div  = chain_div[div_pkg::QUOT_WIDTH];
    assign last_rem  = chain_rem[div_pkg::QUOT_WIDTH];
    assign rem_sign  = last_rem[div_pkg::REM_WIDTH-1];

    // recorded bits are shifted once more with the implied final 1
    assign last_quot = {chain_quot[div_pkg::QUOT_WIDTH][div_pkg::QUOT_WIDTH-2:0], 1'b1};

    always_comb begin
        step_up   = 1'b0;
        step_down = 1'b0;
        if (last_rem == last_div) begin
            step_up = 1'b1;
        end else if (last_rem == -last_div) begin
            step_down = 1'b1;
        end else if (last_rem != '0 && rem_sign != last_sign) begin
            // pull the remainder back to the dividend's sign
            if (rem_sign == last_div[div_pkg::DIVISOR_WIDTH-1]) begin
                step_up = 1'b1;
            end else begin
                step_down = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage_en[div_pkg::PIPE_STAGES-1]) begin
            res_tag <= last_tag;
            if (step_up) begin
                res_quotient  <= last_quot + 1'b1;
                res_remainder <= last_rem - last_div;
            end else if (step_down) begin
                res_quotient  <= last_quot - 1'b1;
                res_remainder <= last_rem + last_div;
            end else begin
                res_quotient  <= last_quot;
                res_remainder <= last_rem;
            end
        end
    end

endmodule

//--- src/div_stage_control.sv
/*
 * Stall control for the divider pipeline:
 *   valid bit per pipeline stage
 *   global advance condition and stage enables
 *   input ready and FIFO push
 */
`timescale 1ns/1ps

module div_stage_control (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            in_valid,
    input  logic                            full,
    output logic [div_pkg::PIPE_STAGES-1:0] stage_en,
    output logic                            in_ready,
    output logic                            push
);

    logic [div_pkg::PIPE_STAGES-1:0] stage_valid;
    logic                            last_valid;
    logic                            advance;

    // ------------------------------------------------------------------------
    // advance condition
    // ------------------------------------------------------------------------

    assign last_valid = stage_valid[div_pkg::PIPE_STAGES-1];

    // the whole pipeline moves together or not at all
    assign advance = !last_valid || !full;

    assign stage_en = {div_pkg::PIPE_STAGES{advance}};
    assign in_ready = advance;

    // result leaves the normalization register into the FIFO
    assign push = last_valid && advance;

    // ------------------------------------------------------------------------
    // valid tracking
    // ------------------------------------------------------------------------

    // in_ready equals advance, so in_valid here is exactly the transfer
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[div_pkg::PIPE_STAGES-2:0], in_valid};
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------

    // a push into a full buffer would drop a result
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        push |-> !full
    ) else $error("push while result FIFO is full");

endmodule

//--- src/div_pkg.sv
/*
 * Shared definitions for the pipelined signed divider:
 *   operand, result and tag widths
 *   pipeline depth, result FIFO depth and pointer sizes
 *   operand, result and tag vector types
 */
package div_pkg;

    // ------------------------------------------------------------------------
    // operand and result widths
    localparam int DIVIDEND_WIDTH = 16;
    localparam int DIVISOR_WIDTH  = 16;
    localparam int QUOT_WIDTH     = DIVIDEND_WIDTH;
    localparam int REM_WIDTH      = DIVISOR_WIDTH;
    localparam int TAG_WIDTH      = 4;

    // operand register, one stage per quotient bit, normalization
    localparam int PIPE_STAGES = 1 + QUOT_WIDTH + 1;

    // ------------------------------------------------------------------------
    // result buffer
    localparam int FIFO_DEPTH     = 4;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    localparam logic [FIFO_PTR_WIDTH-1:0] FIFO_LAST_PTR   = FIFO_PTR_WIDTH'(FIFO_DEPTH - 1);
    localparam logic [FIFO_CNT_WIDTH-1:0] FIFO_FULL_COUNT = FIFO_CNT_WIDTH'(FIFO_DEPTH);

    // ------------------------------------------------------------------------
    // vector types
    typedef logic signed [DIVIDEND_WIDTH-1:0] dividend_t;
    typedef logic signed [DIVISOR_WIDTH-1:0]  divisor_t;
    typedef logic signed [QUOT_WIDTH-1:0]     quotient_t;
    typedef logic signed [REM_WIDTH-1:0]      remainder_t;
    typedef logic        [TAG_WIDTH-1:0]      tag_t;

endpackage
